// File: source/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int unsigned XLEN = 32;

    // Fetch address, low two bits always zero
    typedef logic [XLEN-1:0] pc_t;

    // Raw instruction word
    typedef logic [31:0] instr_t;

    // RV32I major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        LOAD     = 7'b0000011,
        MISC_MEM = 7'b0001111,
        OP_IMM   = 7'b0010011,
        AUIPC    = 7'b0010111,
        STORE    = 7'b0100011,
        OP       = 7'b0110011,
        LUI      = 7'b0110111,
        BRANCH   = 7'b1100011,
        JALR     = 7'b1100111,
        JAL      = 7'b1101111,
        SYSTEM   = 7'b1110011
    } rv_opcode_e;

    // Coarse class handed to decode
    typedef enum logic [2:0] {
        CLS_ALU     = 3'd0,
        CLS_LOAD    = 3'd1,
        CLS_STORE   = 3'd2,
        CLS_BRANCH  = 3'd3,
        CLS_JUMP    = 3'd4,
        CLS_SYSTEM  = 3'd5,
        CLS_ILLEGAL = 3'd6
    } instr_class_e;

endpackage

`default_nettype wire

// File: source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    localparam int unsigned EPOCH_W = 2;

    // Redirect generation, bumped on every mispredict or nuke
    typedef logic [EPOCH_W-1:0] epoch_t;

    // Controller state
    // ST_HALTED waits for resume after a nuke
    typedef enum logic [0:0] {
        ST_FETCH  = 1'b0,
        ST_HALTED = 1'b1
    } fetch_state_e;

endpackage

`default_nettype wire

// File: source/fetch_ctl.sv
`default_nettype none

module fetch_ctl #(
    parameter isa_pkg::pc_t RESET_PC = '0,
    parameter int BUF_DEPTH = 4,
    localparam int CRD_W = $clog2(BUF_DEPTH) + 2
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  br_mispred_valid,
    input  isa_pkg::pc_t          br_mispred_pc,
    input  logic                  nuke_valid,
    input  isa_pkg::pc_t          nuke_pc,
    input  logic                  resume_fetch,

    input  logic [CRD_W-1:0]      credit_return,

    output logic                  req_valid,
    output isa_pkg::pc_t          req_pc,
    output fetch_pkg::epoch_t     req_epoch,
    output logic                  flush,
    output fetch_pkg::epoch_t     cur_epoch
);

    import isa_pkg::*;
    import fetch_pkg::*;

    fetch_state_e     state_q;
    pc_t              pc_q;
    epoch_t           epoch_q;
    logic [CRD_W-1:0] credits_q;

    logic take_nuke;
    logic take_mispred;
    logic redirect;
    logic issue;

    // Redirect arbitration
    always_comb begin
        // Nuke beats mispredict
        take_nuke    = nuke_valid;
        // Mispredicts while halted belong to a dead path
        take_mispred = br_mispred_valid & ~nuke_valid & (state_q == ST_FETCH);
        redirect     = take_nuke | take_mispred;
        // Need a free buffer slot and a quiet cycle
        issue        = (state_q == ST_FETCH) & (credits_q != '0) & ~redirect;
    end

    // Buffer must drop old path at this same edge
    assign flush     = redirect;
    assign cur_epoch = epoch_q;

    // PC, epoch and FSM
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_FETCH;
            pc_q    <= RESET_PC;
            epoch_q <= '0;
        end else if (take_nuke) begin
            // Park at nuke target
            state_q <= ST_HALTED;
            pc_q    <= {nuke_pc[31:2], 2'b00};
            epoch_q <= epoch_q + 1'b1;
        end else if (take_mispred) begin
            // Restart immediately at branch target
            pc_q    <= {br_mispred_pc[31:2], 2'b00};
            epoch_q <= epoch_q + 1'b1;
        end else if (state_q == ST_HALTED) begin
            if (resume_fetch) begin
                state_q <= ST_FETCH;
            end
        end else if (issue) begin
            // Sequential path only
            pc_q <= pc_q + 32'd4;
        end
    end

    // Credit counter
    // One spent per issue, refunds come from the buffer
    always_ff @(posedge clk) begin
        if (reset) begin
            credits_q <= CRD_W'(BUF_DEPTH);
        end else begin
            credits_q <= credits_q - CRD_W'(issue) + credit_return;
        end
    end

    // Request register stage toward memory port
    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_pc    <= pc_q;
            // Tag with the generation it was fetched under
            req_epoch <= epoch_q;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_mem_pipe.sv
`default_nettype none

module fetch_mem_pipe #(
    parameter int MEM_LATENCY = 3
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    req_valid,
    input  isa_pkg::pc_t            req_pc,
    input  fetch_pkg::epoch_t       req_epoch,

    output logic                    ic_mem_req_valid,
    output isa_pkg::pc_t            ic_mem_addr,
    input  isa_pkg::instr_t         ic_mem_rdata,

    output logic                    rsp_valid,
    output isa_pkg::pc_t            rsp_pc,
    output isa_pkg::instr_t         rsp_instr,
    output isa_pkg::instr_class_e   rsp_class,
    output fetch_pkg::epoch_t       rsp_epoch
);

    import isa_pkg::*;
    import fetch_pkg::*;

    // In-flight tag pipeline, one slot per cycle of memory latency
    logic [MEM_LATENCY-1:0] vld_q;
    pc_t                    pc_q [MEM_LATENCY];
    epoch_t                 ep_q [MEM_LATENCY];

    rv_opcode_e   opcode;
    instr_class_e cls;

    // Memory port
    assign ic_mem_req_valid = req_valid;
    assign ic_mem_addr      = req_pc;

    // Valid bits, cleared on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= req_valid;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // Address and epoch ride along
    always_ff @(posedge clk) begin
        pc_q[0] <= req_pc;
        ep_q[0] <= req_epoch;
        for (int i = 1; i < MEM_LATENCY; i++) begin
            pc_q[i] <= pc_q[i-1];
            ep_q[i] <= ep_q[i-1];
        end
    end

    // Predecode on returning word
    always_comb begin
        opcode = rv_opcode_e'(ic_mem_rdata[6:0]);
        case (opcode)
            OP_IMM, OP, LUI, AUIPC: cls = CLS_ALU;
            LOAD:                   cls = CLS_LOAD;
            STORE:                  cls = CLS_STORE;
            BRANCH:                 cls = CLS_BRANCH;
            JAL, JALR:              cls = CLS_JUMP;
            SYSTEM, MISC_MEM:       cls = CLS_SYSTEM;
            // Compressed or unknown encodings
            default:                cls = CLS_ILLEGAL;
        endcase
    end

    // Response register, data lines up with last tag slot
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= vld_q[MEM_LATENCY-1];
        end
    end

    always_ff @(posedge clk) begin
        rsp_pc    <= pc_q[MEM_LATENCY-1];
        rsp_epoch <= ep_q[MEM_LATENCY-1];
        rsp_instr <= ic_mem_rdata;
        rsp_class <= cls;
    end

endmodule

`default_nettype wire

// File: source/fetch_buf.sv
`default_nettype none

module fetch_buf #(
    parameter int BUF_DEPTH = 4,
    localparam int CRD_W = $clog2(BUF_DEPTH) + 2
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    rsp_valid,
    input  isa_pkg::pc_t            rsp_pc,
    input  isa_pkg::instr_t         rsp_instr,
    input  isa_pkg::instr_class_e   rsp_class,
    input  fetch_pkg::epoch_t       rsp_epoch,

    input  logic                    flush,
    input  fetch_pkg::epoch_t       cur_epoch,
    output logic [CRD_W-1:0]        credit_return,

    input  logic                    decode_ready_de0,
    output logic                    valid_fe1,
    output isa_pkg::pc_t            pc_fe1,
    output isa_pkg::instr_t         instr_fe1,
    output isa_pkg::instr_class_e   class_fe1
);

    import isa_pkg::*;
    import fetch_pkg::*;

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;

    // Entry storage
    pc_t          pc_mem    [BUF_DEPTH];
    instr_t       instr_mem [BUF_DEPTH];
    instr_class_e cls_mem   [BUF_DEPTH];

    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CRD_W-1:0] count_q;

    logic push;
    logic pop;
    logic drop;

    always_comb begin
        // Transfer to decode
        pop  = valid_fe1 & decode_ready_de0;
        // Only current-generation responses get a slot
        push = rsp_valid & (rsp_epoch == cur_epoch) & ~flush;
        // Stale or flushed response, slot never used
        drop = rsp_valid & ~push;
    end

    // Freed slots go back to the controller
    always_comb begin
        if (flush) begin
            // Whole queue plus anything arriving now
            credit_return = count_q + CRD_W'(rsp_valid);
        end else begin
            credit_return = CRD_W'(pop) + CRD_W'(drop);
        end
    end

    // Head of queue to decode
    assign valid_fe1 = (count_q != '0);
    assign pc_fe1    = pc_mem[rd_ptr_q];
    assign instr_fe1 = instr_mem[rd_ptr_q];
    assign class_fe1 = cls_mem[rd_ptr_q];

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                // Manual wrap, depth need not be a power of two
                wr_ptr_q <= (wr_ptr_q == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CRD_W'(push) - CRD_W'(pop);
        end
    end

    // Write port
    // Credits guarantee a free slot here
    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr_q]    <= rsp_pc;
            instr_mem[wr_ptr_q] <= rsp_instr;
            cls_mem[wr_ptr_q]   <= rsp_class;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_top.sv
`default_nettype none

module fetch_top #(
    parameter isa_pkg::pc_t RESET_PC = '0,
    parameter int MEM_LATENCY = 3,
    parameter int BUF_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    br_mispred_valid,
    input  isa_pkg::pc_t            br_mispred_pc,
    input  logic                    nuke_valid,
    input  isa_pkg::pc_t            nuke_pc,
    input  logic                    resume_fetch,

    output logic                    ic_mem_req_valid,
    output isa_pkg::pc_t            ic_mem_addr,
    input  isa_pkg::instr_t         ic_mem_rdata,

    input  logic                    decode_ready_de0,
    output logic                    valid_fe1,
    output isa_pkg::pc_t            pc_fe1,
    output isa_pkg::instr_t         instr_fe1,
    output isa_pkg::instr_class_e   class_fe1
);

    import isa_pkg::*;
    import fetch_pkg::*;

    localparam int CRD_W = $clog2(BUF_DEPTH) + 2;

    // Controller to memory pipe
    logic         req_valid;
    pc_t          req_pc;
    epoch_t       req_epoch;

    // Memory pipe to buffer
    logic         rsp_valid;
    pc_t          rsp_pc;
    instr_t       rsp_instr;
    instr_class_e rsp_class;
    epoch_t       rsp_epoch;

    // Controller and buffer bookkeeping
    logic             flush;
    epoch_t           cur_epoch;
    logic [CRD_W-1:0] credit_return;

    // Stage 1, PC generation and redirects
    fetch_ctl #(
        .RESET_PC  (RESET_PC),
        .BUF_DEPTH (BUF_DEPTH)
    ) fetch_ctl (
        .clk,
        .reset,
        .br_mispred_valid,
        .br_mispred_pc,
        .nuke_valid,
        .nuke_pc,
        .resume_fetch,
        .credit_return,
        .req_valid,
        .req_pc,
        .req_epoch,
        .flush,
        .cur_epoch
    );

    // Stage 2, memory access and predecode
    fetch_mem_pipe #(
        .MEM_LATENCY (MEM_LATENCY)
    ) fetch_mem_pipe (
        .clk,
        .reset,
        .req_valid,
        .req_pc,
        .req_epoch,
        .ic_mem_req_valid,
        .ic_mem_addr,
        .ic_mem_rdata,
        .rsp_valid,
        .rsp_pc,
        .rsp_instr,
        .rsp_class,
        .rsp_epoch
    );

    // Stage 3, queue toward decode
    fetch_buf #(
        .BUF_DEPTH (BUF_DEPTH)
    ) fetch_buf (
        .clk,
        .reset,
        .rsp_valid,
        .rsp_pc,
        .rsp_instr,
        .rsp_class,
        .rsp_epoch,
        .flush,
        .cur_epoch,
        .credit_return,
        .decode_ready_de0,
        .valid_fe1,
        .pc_fe1,
        .instr_fe1,
        .class_fe1
    );

endmodule

`default_nettype wire

// File: sim/fetch_tb.sv
`default_nettype none

module fetch_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import isa_pkg::*;

    localparam pc_t RESET_PC    = 32'h0000_0000;
    localparam int  MEM_LATENCY = 3;
    localparam int  BUF_DEPTH   = 4;
    localparam int  CLK_PERIOD  = 100;

    // Test lengths in clock cycles
    localparam int SEQ_CYC   = 300;
    localparam int MIS_CYC   = 400;
    localparam int NUKE_CYC  = 400;
    localparam int DEC_CYC   = 300;
    localparam int BP_CYC    = 600;
    localparam int DRAIN_CYC = 40;
    localparam int ALL_CYC   = SEQ_CYC + MIS_CYC + NUKE_CYC + DEC_CYC + BP_CYC + DRAIN_CYC;

    logic         clk;
    logic         reset;
    logic         br_mispred_valid;
    pc_t          br_mispred_pc;
    logic         nuke_valid;
    pc_t          nuke_pc;
    logic         resume_fetch;
    logic         ic_mem_req_valid;
    pc_t          ic_mem_addr;
    instr_t       ic_mem_rdata;
    logic         decode_ready_de0;
    logic         valid_fe1;
    pc_t          pc_fe1;
    instr_t       instr_fe1;
    instr_class_e class_fe1;

    // Memory model storage and address delay line
    instr_t mem [1024];
    pc_t    addr_pipe [MEM_LATENCY];

    // Reference model state
    pc_t exp_pc;
    bit  halted;
    int  cooldown;
    int  errors;
    int  tests;
    int  xfers;
    int  reqs_bp;
    int  xfers_bp;
    bit  seen [8];

    fetch_top #(
        .RESET_PC    (RESET_PC),
        .MEM_LATENCY (MEM_LATENCY),
        .BUF_DEPTH   (BUF_DEPTH)
    ) dut (
        .clk              (clk),
        .reset            (reset),
        .br_mispred_valid (br_mispred_valid),
        .br_mispred_pc    (br_mispred_pc),
        .nuke_valid       (nuke_valid),
        .nuke_pc          (nuke_pc),
        .resume_fetch     (resume_fetch),
        .ic_mem_req_valid (ic_mem_req_valid),
        .ic_mem_addr      (ic_mem_addr),
        .ic_mem_rdata     (ic_mem_rdata),
        .decode_ready_de0 (decode_ready_de0),
        .valid_fe1        (valid_fe1),
        .pc_fe1           (pc_fe1),
        .instr_fe1        (instr_fe1),
        .class_fe1        (class_fe1)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Read data shows up MEM_LATENCY cycles after the address
    always @(posedge clk) begin
        addr_pipe[0] <= ic_mem_addr;
        for (int i = 1; i < MEM_LATENCY; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
        end
    end

    assign ic_mem_rdata = mem[addr_pipe[MEM_LATENCY-1][11:2]];

    // Class rule on opcode bits
    function automatic instr_class_e expected_class(input instr_t w);
        instr_class_e c;
        case (w[6:0])
            OP_IMM, OP, LUI, AUIPC: c = CLS_ALU;
            LOAD:                   c = CLS_LOAD;
            STORE:                  c = CLS_STORE;
            BRANCH:                 c = CLS_BRANCH;
            JAL, JALR:              c = CLS_JUMP;
            SYSTEM, MISC_MEM:       c = CLS_SYSTEM;
            default:                c = CLS_ILLEGAL;
        endcase
        return c;
    endfunction

    function automatic pc_t random_pc();
        return $urandom & 32'hffff_fffc;
    endfunction

    task automatic check_pc(input string name, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            $display("** Error: %s: pc_fe1 expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_instr(input string name, input instr_t exp, input instr_t act);
        if (act !== exp) begin
            $display("** Error: %s: instr_fe1 expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_class(input string name, input instr_class_e exp,
                               input instr_class_e act);
        if (act !== exp) begin
            $display("** Error: %s: class_fe1 expected %s, actual %s (%0d)",
                     name, exp.name(), act.name(), act);
            errors++;
        end
    endtask

    // Random words, opcode field forced to a legal opcode or an illegal pattern
    task automatic fill_memory();
        rv_opcode_e ops [11];
        int         sel;
        ops = '{LOAD, STORE, OP_IMM, OP, LUI, AUIPC, BRANCH, JAL, JALR, SYSTEM, MISC_MEM};
        for (int a = 0; a < 1024; a++) begin
            mem[a] = $urandom;
            sel = $urandom % 13;
            if (sel < 11) begin
                mem[a][6:0] = ops[sel];
            end else if (sel == 11) begin
                mem[a][6:0] = 7'h00;
            end else begin
                mem[a][6:0] = 7'h7f;
            end
        end
        for (int i = 0; i < MEM_LATENCY; i++) begin
            addr_pipe[i] = '0;
        end
    endtask

    task automatic apply_reset();
        reset            = 1'b1;
        br_mispred_valid = 1'b0;
        nuke_valid       = 1'b0;
        resume_fetch     = 1'b0;
        decode_ready_de0 = 1'b0;
        repeat (2) @(negedge clk);
        reset    = 1'b0;
        exp_pc   = RESET_PC;
        halted   = 1'b0;
        cooldown = 0;
    endtask

    // One clock cycle, driven and checked at the falling edge
    task automatic run_cycle(input string name, input int idx, input int ready_pct,
                             input int mis_rate, input int nuke_rate, input bit bp);
        instr_t w;
        @(negedge clk);
        if (halted && (valid_fe1 || ic_mem_req_valid)) begin
            $display("%s: fetch activity while halted by a nuke at %0t ns", name, $time);
            errors++;
        end
        // Issued requests against completed transfers
        if (bp) begin
            if (ic_mem_req_valid) begin
                reqs_bp++;
            end
            if (reqs_bp - xfers_bp > BUF_DEPTH) begin
                $display("%s: %0d requests outstanding, more than the %0d buffer slots",
                         name, reqs_bp - xfers_bp, BUF_DEPTH);
                errors++;
            end
        end
        // Inputs for the coming edge
        br_mispred_valid = 1'b0;
        nuke_valid       = 1'b0;
        resume_fetch     = 1'b0;
        if (bp) begin
            // Long stall stretches, short bursts of ready
            decode_ready_de0 = (idx % 80) >= 55;
        end else begin
            decode_ready_de0 = ($urandom % 100) < ready_pct;
        end
        if (cooldown > 0) begin
            cooldown--;
        end
        // Gap between redirects keeps the 2-bit epoch from aliasing
        if (halted) begin
            resume_fetch = ($urandom % 6) == 0;
        end else if (cooldown == 0) begin
            if (nuke_rate != 0 && ($urandom % nuke_rate) == 0) begin
                nuke_valid       = 1'b1;
                nuke_pc          = random_pc();
                // Same-cycle mispredict half the time
                br_mispred_valid = ($urandom % 2) == 0;
                br_mispred_pc    = random_pc();
                cooldown         = 8;
            end else if (mis_rate != 0 && ($urandom % mis_rate) == 0) begin
                br_mispred_valid = 1'b1;
                br_mispred_pc    = random_pc();
                cooldown         = 8;
            end
        end
        // Transfer at the coming edge, still old path
        if (valid_fe1 && decode_ready_de0) begin
            w = mem[exp_pc[11:2]];
            check_pc(name, exp_pc, pc_fe1);
            check_instr(name, w, instr_fe1);
            check_class(name, expected_class(w), class_fe1);
            seen[expected_class(w)] = 1'b1;
            exp_pc = exp_pc + 32'd4;
            xfers++;
            if (bp) begin
                xfers_bp++;
            end
        end
        // Redirect sampled at the coming edge, nuke first
        if (nuke_valid) begin
            exp_pc = nuke_pc;
            halted = 1'b1;
        end else if (br_mispred_valid && !halted) begin
            exp_pc = br_mispred_pc;
        end else if (halted && resume_fetch) begin
            halted = 1'b0;
        end
    endtask

    task automatic run_test(input string name, input int cycles, input int ready_pct,
                            input int mis_rate, input int nuke_rate, input bit bp,
                            input bit want_cov);
        int           err0;
        int           xf0;
        instr_class_e cls;
        err0 = errors;
        xf0  = xfers;
        for (int i = 0; i < cycles; i++) begin
            run_cycle(name, i, ready_pct, mis_rate, nuke_rate, bp);
        end
        if (xfers - xf0 < cycles / 20) begin
            $display("%s: only %0d instructions reached decode", name, xfers - xf0);
            errors++;
        end
        // Every class, CLS_ILLEGAL too
        if (want_cov) begin
            for (int c = 0; c < 7; c++) begin
                if (!seen[c]) begin
                    cls = instr_class_e'(c);
                    $display("%s: class %s never transferred", name, cls.name());
                    errors++;
                end
            end
        end
        tests++;
        $display("%-12s done: %0d cycles, %0d transfers, %0d errors",
                 name, cycles, xfers - xf0, errors - err0);
    endtask

    initial begin
        clk           = 1'b0;
        br_mispred_pc = '0;
        nuke_pc       = '0;
        errors        = 0;
        tests         = 0;
        xfers         = 0;
        void'($urandom(32'h1a7e));
        fill_memory();
        apply_reset();
        run_test("seq_fetch", SEQ_CYC, 70, 0, 0, 1'b0, 1'b0);
        run_test("mispredict", MIS_CYC, 70, 16, 0, 1'b0, 1'b0);
        run_test("nuke_resume", NUKE_CYC, 70, 20, 24, 1'b0, 1'b0);
        run_test("predecode", DEC_CYC, 90, 40, 0, 1'b0, 1'b1);
        // Fresh start so the outstanding count begins at zero
        apply_reset();
        reqs_bp  = 0;
        xfers_bp = 0;
        run_test("backpressure", BP_CYC, 0, 0, 0, 1'b1, 1'b0);
        run_test("drain", DRAIN_CYC, 100, 0, 0, 1'b0, 1'b0);
        $display("%0d tests, %0d transfers, %0d errors", tests, xfers, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(ALL_CYC * 4 * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", ALL_CYC * 4);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
source/isa_pkg.sv
source/fetch_pkg.sv
source/fetch_ctl.sv
source/fetch_mem_pipe.sv
source/fetch_buf.sv
source/fetch_top.sv
sim/fetch_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module fetch_tb -f tb.f -o fetch_tb_sim \
    && ./obj_dir/fetch_tb_sim | tee sim.log \
    || echo "build or simulation failed"
grep -q "Simulation finished: PASS" sim.log 2>/dev/null && exit 0 || exit 1
